//--- can_mon_pkg.sv
// Word layout shared by sampler and monitor, with bits 30..24 and 7..4 of a status word always zero
`default_nettype none

package can_mon_pkg;

  // CAN fault-confinement state as carried in the report
  typedef enum logic [2:0] {
    ERROR_ACTIVE  = 3'd0,
    ERROR_PASSIVE = 3'd1,
    BUS_OFF       = 3'd2
  } node_state_e;

  // Either error counter above this makes the node error-passive
  localparam logic [7:0] ERR_PASSIVE_LIMIT = 8'd127;

  // Values of the kind bit
  localparam logic KIND_STATUS  = 1'b0;
  localparam logic KIND_COMMAND = 1'b1;

  // Status view, bit 31 first
  typedef struct packed {
    logic       kind;
    logic [6:0] reserved_hi;
    logic [7:0] rx_err_count;
    logic [7:0] tx_err_count;
    logic [3:0] reserved_lo;
    logic       bus_off;
    logic       error_detected;
    logic       rx_active;
    logic       tx_active;
  } status_fields_t;

  // Command view, bit 31 first
  typedef struct packed {
    logic        kind;
    logic [29:0] reserved;
    logic        clear_counters;
  } command_fields_t;

  // One stream word, decoded by its kind bit
  typedef union packed {
    status_fields_t  status;
    command_fields_t command;
  } mon_word_u;

endpackage

`default_nettype wire

//--- can_status_sampler.sv
// CAN inputs are assumed synchronous to aclk, and a pulse that ends while the output stalls is missed
`timescale 1ns/1ps
`default_nettype none

module can_status_sampler (
  input  wire                   aclk,
  input  wire                   aresetn,
  input  logic                  tx_active,
  input  logic                  rx_active,
  input  logic                  error_detected,
  input  logic                  bus_off,
  input  logic [7:0]            tx_err_count,
  input  logic [7:0]            rx_err_count,
  input  wire                   clear_req,
  output logic                  word_valid,
  input  wire                   word_ready,
  output can_mon_pkg::mon_word_u word_data
);

  import can_mon_pkg::*;

  // Clear command as sent to the monitor
  localparam command_fields_t CLEAR_CMD = '{
    kind:           KIND_COMMAND,
    reserved:       '0,
    clear_counters: 1'b1
  };

  logic [19:0] cur_sample;
  logic [19:0] last_sample;
  logic        clear_pend;
  logic        can_load;
  logic        load_cmd;
  logic        load_status;
  mon_word_u   status_word;
  mon_word_u   word_q;

  // All monitored inputs as one vector for change detection
  assign cur_sample = {bus_off, error_detected, rx_active, tx_active, rx_err_count, tx_err_count};

  // Output register is free or being emptied this cycle
  assign can_load = !word_valid || word_ready;

  // Pending clear wins over a status change
  assign load_cmd    = can_load && (clear_pend || clear_req);
  assign load_status = can_load && !load_cmd && (cur_sample != last_sample);

  always_comb begin
    status_word                     = '0;
    status_word.status.kind         = KIND_STATUS;
    status_word.status.tx_active    = tx_active;
    status_word.status.rx_active    = rx_active;
    status_word.status.error_detected = error_detected;
    status_word.status.bus_off      = bus_off;
    status_word.status.tx_err_count = tx_err_count;
    status_word.status.rx_err_count = rx_err_count;
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      word_valid  <= 1'b0;
      clear_pend  <= 1'b0;
      last_sample <= '0;
    end else begin
      if (can_load) begin
        word_valid <= load_cmd || load_status;
      end
      // A clear seen in the same cycle as the command is absorbed by it
      if (load_cmd) begin
        clear_pend <= 1'b0;
      end else if (clear_req) begin
        clear_pend <= 1'b1;
      end
      if (load_status) begin
        last_sample <= cur_sample;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (load_cmd) begin
      word_q.command <= CLEAR_CMD;
    end else if (load_status) begin
      word_q <= status_word;
    end
  end

  assign word_data = word_q;

  // Held word must not change until the monitor takes it
  a_word_stable: assert property (
    @(posedge aclk) disable iff (!aresetn)
    word_valid && !word_ready |=> word_valid && $stable(word_data)
  ) else $error("word_data changed while stalled: %h", word_data);

endmodule

`default_nettype wire

//--- can_status_monitor.sv
// Counters wrap at 2**CNT_W and a command word clears them when its clear bit is set
`timescale 1ns/1ps
`default_nettype none

module can_status_monitor #(
  parameter int CNT_W = 15
) (
  input  wire                      aclk,
  input  wire                      aresetn,
  input  wire                      s_axis_tvalid,
  output logic                     s_axis_tready,
  input  can_mon_pkg::mon_word_u   s_axis_tdata,
  output logic                     m_axis_tvalid,
  input  wire                      m_axis_tready,
  output logic [3+3*CNT_W-1:0]     m_axis_tdata
);

  import can_mon_pkg::*;

  node_state_e      node_state;
  logic [CNT_W-1:0] frames_sent;
  logic [CNT_W-1:0] frames_received;
  logic [CNT_W-1:0] errors_detected;
  logic             prev_tx_active;
  logic             prev_rx_active;
  logic             prev_error;
  logic             rpt_valid_q;
  logic             accept;
  logic             is_command;
  status_fields_t   st;

  // Free slot or the held report leaves on this edge
  assign s_axis_tready = !rpt_valid_q || m_axis_tready;
  assign accept        = s_axis_tvalid && s_axis_tready;

  assign is_command = (s_axis_tdata.command.kind == KIND_COMMAND);
  assign st         = s_axis_tdata.status;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      rpt_valid_q <= 1'b0;
    end else if (accept) begin
      rpt_valid_q <= 1'b1;
    end else if (m_axis_tready) begin
      rpt_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      node_state      <= ERROR_ACTIVE;
      frames_sent     <= '0;
      frames_received <= '0;
      errors_detected <= '0;
      prev_tx_active  <= 1'b0;
      prev_rx_active  <= 1'b0;
      prev_error      <= 1'b0;
    end else if (accept) begin
      if (is_command) begin
        // Clear restarts edge detection too and keeps the node state
        if (s_axis_tdata.command.clear_counters) begin
          frames_sent     <= '0;
          frames_received <= '0;
          errors_detected <= '0;
          prev_tx_active  <= 1'b0;
          prev_rx_active  <= 1'b0;
          prev_error      <= 1'b0;
        end
      end else begin
        prev_tx_active <= st.tx_active;
        prev_rx_active <= st.rx_active;
        prev_error     <= st.error_detected;

        // Rising edges against the previous status word
        if (st.tx_active && !prev_tx_active) begin
          frames_sent <= frames_sent + 1'b1;
        end
        if (st.rx_active && !prev_rx_active) begin
          frames_received <= frames_received + 1'b1;
        end
        if (st.error_detected && !prev_error) begin
          errors_detected <= errors_detected + 1'b1;
        end

        if (st.bus_off) begin
          node_state <= BUS_OFF;
        end else if ((st.tx_err_count > ERR_PASSIVE_LIMIT) ||
                     (st.rx_err_count > ERR_PASSIVE_LIMIT)) begin
          node_state <= ERROR_PASSIVE;
        end else begin
          node_state <= ERROR_ACTIVE;
        end
      end
    end
  end

  assign m_axis_tvalid = rpt_valid_q;

  // Errors in the top bits, state in the bottom three
  assign m_axis_tdata = {errors_detected, frames_received, frames_sent, node_state};

  // A held report stays put until the FIFO takes it
  a_rpt_not_overwritten: assert property (
    @(posedge aclk) disable iff (!aresetn)
    rpt_valid_q && !m_axis_tready |=> rpt_valid_q && $stable(m_axis_tdata)
  ) else $error("report overwritten before taken: %h", m_axis_tdata);

endmodule

`default_nettype wire

//--- can_report_fifo.sv
// FIFO_DEPTH must be a power of two of at least 2, and data appears one cycle after a push
`timescale 1ns/1ps
`default_nettype none

module can_report_fifo #(
  parameter int WIDTH      = 48,
  parameter int FIFO_DEPTH = 4
) (
  input  wire              aclk,
  input  wire              aresetn,
  input  wire              in_valid,
  output logic             in_ready,
  input  wire  [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  wire              out_ready,
  output logic [WIDTH-1:0] out_data
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  logic [WIDTH-1:0] mem [FIFO_DEPTH];
  // One extra bit tells full from empty
  logic [ADDR_W:0]  wr_ptr;
  logic [ADDR_W:0]  rd_ptr;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_depth_check
    $error("FIFO_DEPTH must be a power of two of at least 2");
  end

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  assign in_ready  = !full;
  assign out_valid = !empty;
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr[ADDR_W-1:0]] <= in_data;
    end
  end

  assign out_data = mem[rd_ptr[ADDR_W-1:0]];

  // No push when full
  a_no_overflow: assert property (
    @(posedge aclk) disable iff (!aresetn)
    full |=> wr_ptr == $past(wr_ptr)
  ) else $error("push while full: wr_ptr=%h rd_ptr=%h", wr_ptr, rd_ptr);

  // No pop when empty
  a_no_underflow: assert property (
    @(posedge aclk) disable iff (!aresetn)
    empty |=> rd_ptr == $past(rd_ptr)
  ) else $error("pop while empty: wr_ptr=%h rd_ptr=%h", wr_ptr, rd_ptr);

endmodule

`default_nettype wire

//--- can_monitor_top.sv
// Report latency is 3 cycles from a CAN input change when no stage stalls and tlast is always high
`timescale 1ns/1ps
`default_nettype none

module can_monitor_top #(
  parameter int CNT_W      = 15,
  parameter int FIFO_DEPTH = 4
) (
  input  wire                  aclk,
  input  wire                  aresetn,
  input  wire                  tx_active,
  input  wire                  rx_active,
  input  wire                  error_detected,
  input  wire                  bus_off,
  input  wire  [7:0]           tx_err_count,
  input  wire  [7:0]           rx_err_count,
  input  wire                  clear_req,
  output logic                 m_axis_tvalid,
  input  wire                  m_axis_tready,
  output logic [3+3*CNT_W-1:0] m_axis_tdata,
  output logic                 m_axis_tlast
);

  import can_mon_pkg::*;

  localparam int RPT_W = 3 + 3 * CNT_W;

  logic             word_valid;
  logic             word_ready;
  mon_word_u        word_data;
  logic             rpt_valid;
  logic             rpt_ready;
  logic [RPT_W-1:0] rpt_data;

  can_status_sampler u_sampler (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .tx_active      (tx_active),
    .rx_active      (rx_active),
    .error_detected (error_detected),
    .bus_off        (bus_off),
    .tx_err_count   (tx_err_count),
    .rx_err_count   (rx_err_count),
    .clear_req      (clear_req),
    .word_valid     (word_valid),
    .word_ready     (word_ready),
    .word_data      (word_data)
  );

  can_status_monitor #(
    .CNT_W (CNT_W)
  ) u_monitor (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tvalid (word_valid),
    .s_axis_tready (word_ready),
    .s_axis_tdata  (word_data),
    .m_axis_tvalid (rpt_valid),
    .m_axis_tready (rpt_ready),
    .m_axis_tdata  (rpt_data)
  );

  can_report_fifo #(
    .WIDTH      (RPT_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (rpt_valid),
    .in_ready  (rpt_ready),
    .in_data   (rpt_data),
    .out_valid (m_axis_tvalid),
    .out_ready (m_axis_tready),
    .out_data  (m_axis_tdata)
  );

  // Every report is a complete packet
  assign m_axis_tlast = 1'b1;

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// Free-running clock from time zero, reset released 2 ns after the last reset edge
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic aclk,
  output logic aresetn
);

  initial begin
    aclk = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      aclk = ~aclk;
    end
  end

  initial begin
    aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    #2;
    aresetn = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_can_monitor.sv
// Bursts never exceed FIFO_DEPTH changes, so every input change or clear yields exactly one report
`timescale 1ns/1ps
`default_nettype none

module tb_can_monitor;

  import can_mon_pkg::*;

  localparam int CNT_W      = 15;
  localparam int FIFO_DEPTH = 4;
  localparam int RPT_W      = 3 + 3 * CNT_W;
  localparam int N_BURSTS   = 40;
  localparam int WRAP_RISES = (1 << CNT_W) + 2;
  localparam int NUM_TESTS  = 20 + N_BURSTS * FIFO_DEPTH + 2 * WRAP_RISES;

  logic             aclk;
  logic             aresetn;
  logic             tx_active, rx_active, error_detected, bus_off;
  logic [7:0]       tx_err_count, rx_err_count;
  logic             clear_req;
  logic             m_axis_tvalid, m_axis_tready, m_axis_tlast;
  logic [RPT_W-1:0] m_axis_tdata;

  // Reference model of the counters and state
  logic [CNT_W-1:0] ref_sent, ref_recv, ref_err;
  logic             ref_prev_tx, ref_prev_rx, ref_prev_err;
  node_state_e      ref_state;
  logic [RPT_W-1:0] exp_q[$];
  logic [RPT_W-1:0] head_data;
  logic [RPT_W-1:0] last_rpt;
  logic             head_valid;
  logic             bp_random;
  logic             inputs_changed;
  int               data_errors;
  int               protocol_errors;
  int               steps;

  tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) u_clk_gen (.aclk(aclk), .aresetn(aresetn));

  can_monitor_top #(
    .CNT_W      (CNT_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_can_monitor_top (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .tx_active      (tx_active),
    .rx_active      (rx_active),
    .error_detected (error_detected),
    .bus_off        (bus_off),
    .tx_err_count   (tx_err_count),
    .rx_err_count   (rx_err_count),
    .clear_req      (clear_req),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tready  (m_axis_tready),
    .m_axis_tdata   (m_axis_tdata),
    .m_axis_tlast   (m_axis_tlast)
  );

  // Bus-off wins over either counter being above the limit
  function automatic node_state_e expected_state(input logic boff, input logic [7:0] tec,
                                                 input logic [7:0] rec);
    if (boff) begin
      return BUS_OFF;
    end
    if (tec > ERR_PASSIVE_LIMIT || rec > ERR_PASSIVE_LIMIT) begin
      return ERROR_PASSIVE;
    end
    return ERROR_ACTIVE;
  endfunction

  function automatic logic [RPT_W-1:0] reference_report();
    return {ref_err, ref_recv, ref_sent, ref_state};
  endfunction

  task automatic next_cycle();
    @(posedge aclk);
    #2;
    clear_req     = 1'b0;
    m_axis_tready = bp_random ? 1'($urandom_range(0, 1)) : 1'b1;
  endtask

  // flags are {bus_off, error_detected, rx_active, tx_active}
  task automatic apply_status(input logic [3:0] flags, input logic [7:0] tec,
                              input logic [7:0] rec);
    if (flags[0] && !ref_prev_tx) begin
      ref_sent = ref_sent + 1'b1;
    end
    if (flags[1] && !ref_prev_rx) begin
      ref_recv = ref_recv + 1'b1;
    end
    if (flags[2] && !ref_prev_err) begin
      ref_err = ref_err + 1'b1;
    end
    ref_prev_tx  = flags[0];
    ref_prev_rx  = flags[1];
    ref_prev_err = flags[2];
    ref_state    = expected_state(flags[3], tec, rec);
    exp_q.push_back(reference_report());
    {bus_off, error_detected, rx_active, tx_active} = flags;
    tx_err_count   = tec;
    rx_err_count   = rec;
    inputs_changed = 1'b1;
  endtask

  // Clear zeroes counters and edge history but keeps the state
  task automatic apply_clear();
    ref_sent     = '0;
    ref_recv     = '0;
    ref_err      = '0;
    ref_prev_tx  = 1'b0;
    ref_prev_rx  = 1'b0;
    ref_prev_err = 1'b0;
    exp_q.push_back(reference_report());
    clear_req      = 1'b1;
    inputs_changed = 1'b1;
  endtask

  task automatic random_step();
    logic [3:0] flags;
    logic [7:0] tec;
    logic [7:0] rec;
    flags    = 4'($urandom);
    flags[3] = ($urandom_range(0, 5) == 0);
    // Error counts hover around the passive limit
    tec = 8'($urandom_range(100, 155));
    rec = 8'($urandom_range(100, 155));
    if ({flags, tec, rec} ==
        {bus_off, error_detected, rx_active, tx_active, tx_err_count, rx_err_count}) begin
      flags[0] = !flags[0];
    end
    apply_status(flags, tec, rec);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 200) begin
      next_cycle();
      waited++;
    end
    a_drained: assert (exp_q.size() == 0) else begin
      protocol_errors++;
      $display("%0d expected reports never arrived within %0d cycles", exp_q.size(), waited);
    end
    next_cycle();
  endtask

  // Transfer seen at the falling edge takes effect on the next rising edge
  always @(negedge aclk) begin
    if (aresetn && m_axis_tvalid && m_axis_tready) begin
      head_valid = (exp_q.size() != 0);
      if (head_valid) begin
        head_data = exp_q.pop_front();
      end
      last_rpt = m_axis_tdata;
    end
  end

  a_idle_after_reset: assert property (@(posedge aclk) disable iff (!aresetn)
    !inputs_changed |-> !m_axis_tvalid)
  else begin
    protocol_errors++;
    $display("A report appeared before any input changed");
  end

  a_tlast: assert property (@(posedge aclk) disable iff (!aresetn)
    m_axis_tvalid |-> m_axis_tlast)
  else begin
    protocol_errors++;
    $display("Error: m_axis_tlast %h with m_axis_tvalid high", $sampled(m_axis_tlast));
  end

  a_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata))
  else begin
    protocol_errors++;
    $display("Error: m_axis_tdata %h not held while stalled", $sampled(m_axis_tdata));
  end

  a_no_extra: assert property (@(posedge aclk) disable iff (!aresetn)
    m_axis_tvalid && m_axis_tready |-> head_valid)
  else begin
    protocol_errors++;
    $display("A report was taken when none was expected");
  end

  a_report: assert property (@(posedge aclk) disable iff (!aresetn)
    m_axis_tvalid && m_axis_tready && head_valid |-> m_axis_tdata == head_data)
  else begin
    data_errors++;
    $display("Error: m_axis_tdata got %h expected %h", $sampled(m_axis_tdata),
             $sampled(head_data));
  end

  initial begin
    void'($urandom(32'h04be_014f));
    {tx_active, rx_active, error_detected, bus_off} = 4'b0000;
    tx_err_count    = 8'h00;
    rx_err_count    = 8'h00;
    clear_req       = 1'b0;
    m_axis_tready   = 1'b1;
    bp_random       = 1'b0;
    inputs_changed  = 1'b0;
    {ref_sent, ref_recv, ref_err} = '0;
    {ref_prev_tx, ref_prev_rx, ref_prev_err} = 3'b000;
    ref_state       = ERROR_ACTIVE;
    head_valid      = 1'b0;
    head_data       = '0;
    last_rpt        = '0;
    data_errors     = 0;
    protocol_errors = 0;
    wait (aresetn === 1'b1);
    repeat (10) next_cycle();

    // Node state priority
    next_cycle();
    apply_status(4'b0000, 8'd128, 8'd0);
    drain();
    apply_status(4'b0000, 8'd127, 8'd127);
    drain();
    apply_status(4'b0000, 8'd5, 8'd200);
    drain();
    apply_status(4'b1000, 8'd200, 8'd200);
    drain();
    apply_status(4'b0000, 8'd0, 8'd0);
    drain();

    // Single edges, then a clear and counting from zero
    for (int i = 0; i < 3; i++) begin
      apply_status(4'b0001, 8'd0, 8'd0);
      next_cycle();
      apply_status(4'b0110, 8'd0, 8'd0);
      next_cycle();
      apply_status(4'b0000, 8'd0, 8'd0);
      drain();
    end
    apply_clear();
    drain();
    apply_status(4'b0101, 8'd1, 8'd0);
    drain();

    // Short bursts under random back-pressure
    bp_random = 1'b1;
    for (int b = 0; b < N_BURSTS; b++) begin
      steps = $urandom_range(1, FIFO_DEPTH);
      for (int s = 0; s < steps; s++) begin
        next_cycle();
        if ($urandom_range(0, 7) == 0) begin
          apply_clear();
        end else begin
          random_step();
        end
      end
      drain();
    end

    // Streaming at full rate until all three counters wrap
    bp_random = 1'b0;
    next_cycle();
    if ({error_detected, rx_active, tx_active} != 3'b000) begin
      apply_status({bus_off, 3'b000}, tx_err_count, rx_err_count);
      next_cycle();
    end
    for (int i = 0; i < WRAP_RISES; i++) begin
      apply_status({bus_off, 3'b111}, tx_err_count, rx_err_count);
      next_cycle();
      apply_status({bus_off, 3'b000}, tx_err_count, rx_err_count);
      next_cycle();
    end
    drain();
    repeat (10) next_cycle();

    a_final: assert (last_rpt == reference_report()) else begin
      data_errors++;
      $display("Error: final m_axis_tdata %h expected %h", last_rpt, reference_report());
    end
    $display("Summary: %0d data errors, %0d protocol errors", data_errors, protocol_errors);
    if (data_errors + protocol_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // 200 cycles of 40 ns per test step
  initial begin
    #(longint'(NUM_TESTS) * 200 * 40);
    $display("Watchdog expired before the test sequence finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
can_mon_pkg.sv
can_status_sampler.sv
can_status_monitor.sv
can_report_fifo.sv
can_monitor_top.sv
tb_clk_gen.sv
tb_can_monitor.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
		--top-module tb_can_monitor -Mdir obj_dir
	./obj_dir/Vtb_can_monitor | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
